/* all.f */
src/cache_pkg.sv
src/cache_ram.sv
src/cache_way.sv
src/lru_order.sv
src/cache_ctrl.sv
src/cache_top.sv
bench/tb_clock.sv
bench/cache_checker.sv
bench/tb_cache.sv

/* bench/cache_checker.sv */
// Watches the cache ports and checks every access against a reference model.
// Keeps a shadow word memory plus per-set tags, dirty bits and replacement
// order, and checks read data, hit timing and all memory traffic.

module cache_checker import cache_pkg::*; #(
    parameter int INDEX_W = 3
) (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t i_p_req,
    input  word_t    i_p_readdata,
    input  logic     i_p_readdata_valid,
    input  logic     i_p_waitrequest,
    input  mem_req_t i_m_req,
    input  mem_rsp_t i_m_rsp,
    input  logic     i_done,
    output int       o_errors,
    output logic     o_reported
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETS  = 2 ** INDEX_W;
    localparam int TAG_W = ADDR_W - 2 - INDEX_W;
    localparam lru_order_t START = {2'd3, 2'd2, 2'd1, 2'd0};  // way 0 least recent

    word_t                 shadow [logic [ADDR_W-1:0]];  // only words that were written
    logic                  sh_valid [SETS][WAYS];
    logic                  sh_dirty [SETS][WAYS];
    logic [TAG_W-1:0]      sh_tag [SETS][WAYS];
    lru_order_t            sh_order [SETS];
    int                    filled [SETS];

    string                 name;  // kind of the current request
    logic [ADDR_W-1:0]     p_addr;
    logic                  pend;
    logic                  p_read;
    logic                  p_hit;
    logic                  p_wb;
    logic [MEM_ADDR_W-1:0] wb_addr;
    logic [MEM_ADDR_W-1:0] fetch_addr;
    line_t                 wb_line;
    word_t                 exp_data;
    int                    p_cycle;
    int                    n_wb;
    int                    n_fetch;
    int                    n_data;
    int                    n_busy;
    int                    cycle;
    int                    rst_cycles;
    int                    checks;

    initial begin
        o_errors   = 0;
        o_reported = 1'b0;
        pend       = 1'b0;
        cycle      = 0;
        rst_cycles = 0;
        checks     = 0;
        for (int s = 0; s < SETS; s++) begin
            filled[s]   = 0;
            sh_order[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
    end

    // contents of memory that was never written
    function automatic word_t init_word(logic [ADDR_W-1:0] a);
        return {a[15:0], a[24:16], 7'h2b} ^ 32'h6d2e_91c7;
    endfunction

    function automatic word_t shadow_word(logic [ADDR_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    function automatic line_t shadow_line(logic [ADDR_W-3:0] la);
        line_t res;
        for (int w = 0; w < WORDS; w++) begin
            res[w] = shadow_word({la, w[1:0]});
        end
        return res;
    endfunction

    function automatic word_t merge_word(word_t old, word_t data, logic [3:0] be);
        word_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = be[b] ? data[8*b +: 8] : old[8*b +: 8];
        end
        return res;
    endfunction

    // keep the other ways in their relative order, put way on top
    function automatic lru_order_t promote(lru_order_t ord, way_idx_t way);
        lru_order_t res;
        int         k;
        res = ord;
        k   = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (ord[i] != way && k < WAYS - 1) begin
                res[k] = ord[i];
                k++;
            end
        end
        res[WAYS-1] = way;
        return res;
    endfunction

    task automatic compare(string what, logic [127:0] exp, logic [127:0] act);
        checks++;
        if (exp !== act) begin
            o_errors++;
            $display("ERROR %s %s at %h: expected %0h, actual %0h", name, what, p_addr, exp, act);
        end
    endtask

    task automatic report_fault(string msg);
        o_errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    // the previous request must have seen exactly the predicted traffic
    task automatic close_request();
        if (pend) begin
            compare("write-back count", p_wb ? 1 : 0, n_wb);
            compare("fetch count", p_hit ? 0 : 1, n_fetch);
            compare("read response count", p_read ? 1 : 0, n_data);
            if (p_hit && !p_read) begin
                compare("write hit busy cycles", 2, n_busy);
            end
        end
        pend = 1'b0;
    endtask

    task automatic open_request();
        logic [INDEX_W-1:0] set;
        logic [TAG_W-1:0]   tag;
        int                 way;
        p_addr     = i_p_req.addr;
        set        = p_addr[2 +: INDEX_W];
        tag        = p_addr[ADDR_W-1 -: TAG_W];
        way        = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (sh_valid[set][w] && sh_tag[set][w] == tag) begin
                way = w;
            end
        end
        p_read     = i_p_req.read;
        p_hit      = (way >= 0);
        p_wb       = 1'b0;
        fetch_addr = {p_addr[ADDR_W-1:2], 3'b000};
        if (!p_hit) begin
            if (filled[set] < WAYS) begin
                way = filled[set];  // empty ways fill in order
                if (filled[set] == 0) begin
                    sh_order[set] = START;
                end
                filled[set]++;
            end else begin
                way = sh_order[set][0];
                if (sh_dirty[set][way]) begin
                    p_wb    = 1'b1;
                    wb_addr = {sh_tag[set][way], set, 3'b000};
                    wb_line = shadow_line({sh_tag[set][way], set});
                end
            end
            sh_valid[set][way] = 1'b1;
            sh_tag[set][way]   = tag;
            sh_dirty[set][way] = 1'b0;
        end
        sh_order[set] = promote(sh_order[set], way_idx_t'(way));
        if (p_read) begin
            exp_data = shadow_word(p_addr);
        end else begin
            shadow[p_addr] = merge_word(shadow_word(p_addr), i_p_req.writedata, i_p_req.byte_en);
            sh_dirty[set][way] = 1'b1;
        end
        name    = $sformatf("%s_%s", p_read ? "read" : "write", p_hit ? "hit" : "miss");
        p_cycle = cycle;
        n_wb    = 0;
        n_fetch = 0;
        n_data  = 0;
        n_busy  = 0;
        pend    = 1'b1;
    endtask

    task automatic watch_memory();
        if ((i_m_req.read || i_m_req.write) && i_m_req.addr[2:0] != 3'b000) begin
            report_fault("memory request address is not line aligned");
        end
        if (i_m_req.write && !i_m_rsp.waitrequest) begin
            n_wb++;
            if (p_wb) begin
                compare("write-back address", wb_addr, i_m_req.addr);
                compare("write-back line", wb_line, i_m_req.writedata);
            end
        end
        if (i_m_req.read && !i_m_rsp.waitrequest) begin
            n_fetch++;
            compare("fetch address", fetch_addr, i_m_req.addr);
        end
    endtask

    task automatic watch_read();
        if (i_p_readdata_valid) begin
            n_data++;
            if (!pend || !p_read) begin
                report_fault("read data returned with no read outstanding");
            end else begin
                compare("read data", exp_data, i_p_readdata);
                if (p_hit) begin
                    compare("hit latency", 2, cycle - p_cycle);
                end
            end
        end
    endtask

    // sampled mid-cycle, well away from the edges
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            rst_cycles++;
            if (rst_cycles > 1 && {i_p_waitrequest, i_p_readdata_valid,
                                   i_m_req.read, i_m_req.write} !== 4'b0000) begin
                report_fault("cache outputs are not idle in reset");
            end
        end else begin
            cycle++;
            if (pend && i_p_waitrequest) begin
                n_busy++;
            end
            watch_memory();
            watch_read();
            if (!i_p_waitrequest && (i_p_req.read || i_p_req.write)) begin
                close_request();
                open_request();
            end
            if (i_done && !o_reported) begin
                close_request();
                $display("checker: %0d checks, %0d errors", checks, o_errors);
                o_reported = 1'b1;
            end
        end
    end

endmodule

/* bench/tb_cache.sv */
// Testbench top for the four-way cache with eight sets.
// Runs directed hit/miss/eviction cases and then random traffic over two
// sets; a line memory model with fixed delays answers the memory port.

module tb_cache import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int INDEX_W     = 3;
    localparam int DRIVE_DELAY = 10;
    localparam int N_DIRECTED  = 17;
    localparam int N_RANDOM    = 400;
    localparam int CYCLE_LIMIT = 60 * (N_DIRECTED + N_RANDOM);

    logic     clk;
    logic     rst;
    cpu_req_t p_req;
    word_t    p_readdata;
    logic     p_readdata_valid;
    logic     p_waitrequest;
    mem_req_t m_req;
    mem_rsp_t m_rsp;
    logic     run_done;
    logic     reported;
    int       errors;
    int       cycle_count = 0;

    line_t mem_lines [logic [MEM_ADDR_W-4:0]];  // lines written back, by line address

    tb_clock u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    cache_top #(.INDEX_W(INDEX_W)) uut (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (p_req),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_m_req            (m_req),
        .i_m_rsp            (m_rsp)
    );

    cache_checker #(.INDEX_W(INDEX_W)) u_checker (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (p_req),
        .i_p_readdata       (p_readdata),
        .i_p_readdata_valid (p_readdata_valid),
        .i_p_waitrequest    (p_waitrequest),
        .i_m_req            (m_req),
        .i_m_rsp            (m_rsp),
        .i_done             (run_done),
        .o_errors           (errors),
        .o_reported         (reported)
    );

    function automatic word_t init_word(logic [ADDR_W-1:0] a);
        return {a[15:0], a[24:16], 7'h2b} ^ 32'h6d2e_91c7;
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(int tag, int set, int word);
        return (tag << (INDEX_W + 2)) | (set << 2) | word;
    endfunction

    function automatic line_t read_line(logic [MEM_ADDR_W-4:0] key);
        line_t res;
        if (mem_lines.exists(key)) begin
            return mem_lines[key];
        end
        for (int w = 0; w < WORDS; w++) begin
            res[w] = init_word({key, w[1:0]});
        end
        return res;
    endfunction

    // memory model waits two cycles before accepting and returns read data 3 cycles later
    initial begin
        logic                  is_read;
        logic [MEM_ADDR_W-4:0] key;
        m_rsp = '0;
        m_rsp.waitrequest = 1'b1;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (m_req.read || m_req.write) begin
                repeat (2) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                is_read = m_req.read;
                key     = m_req.addr[MEM_ADDR_W-1:3];
                if (!is_read) begin
                    mem_lines[key] = m_req.writedata;
                end
                m_rsp.waitrequest = 1'b0;
                @(posedge clk);
                #DRIVE_DELAY;
                m_rsp.waitrequest = 1'b1;
                if (is_read) begin
                    repeat (2) begin
                        @(posedge clk);
                        #DRIVE_DELAY;
                    end
                    m_rsp.readdata       = read_line(key);
                    m_rsp.readdata_valid = 1'b1;
                    @(posedge clk);
                    #DRIVE_DELAY;
                    m_rsp.readdata_valid = 1'b0;
                end
            end
        end
    end

    // one request, then wait until the cache is idle again
    task automatic issue_request(logic wr, logic [ADDR_W-1:0] addr, logic [3:0] be, word_t data);
        while (p_waitrequest) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        p_req.addr      = addr;
        p_req.byte_en   = be;
        p_req.writedata = data;
        p_req.read      = !wr;
        p_req.write     = wr;
        @(posedge clk);
        #DRIVE_DELAY;
        p_req.read  = 1'b0;
        p_req.write = 1'b0;
        while (p_waitrequest) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int                seed;
        logic [ADDR_W-1:0] addr;
        seed     = 32'h7aab06f7;
        void'($urandom(seed));
        p_req    = '0;
        run_done = 1'b0;
        wait (!rst);
        @(posedge clk);
        #DRIVE_DELAY;
        issue_request(1'b0, addr_of(1, 2, 1), 4'hf, '0);  // cold miss
        issue_request(1'b0, addr_of(1, 2, 3), 4'hf, '0);  // hit in the same line
        issue_request(1'b1, addr_of(1, 2, 0), 4'b0101, 32'hdead_beef);
        issue_request(1'b0, addr_of(1, 2, 0), 4'hf, '0);
        issue_request(1'b1, addr_of(2, 5, 2), 4'b1000, 32'h1234_5678);  // partial write miss
        issue_request(1'b0, addr_of(2, 5, 2), 4'hf, '0);
        // five dirty lines in set 4, then bring the first one back
        for (int t = 10; t < 15; t++) begin
            issue_request(1'b1, addr_of(t, 4, t % 4), 4'hf, 32'h100 * t);
        end
        issue_request(1'b0, addr_of(10, 4, 2), 4'hf, '0);
        for (int t = 20; t < 25; t++) begin
            issue_request(1'b0, addr_of(t, 6, 1), 4'hf, '0);  // clean victims
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            addr = addr_of(30 + $urandom_range(0, 5), ($urandom_range(0, 1) != 0) ? 3 : 7,
                           $urandom_range(0, 3));
            issue_request(1'($urandom_range(0, 1)), addr, 4'($urandom_range(0, 15)), $urandom);
        end
        run_done = 1'b1;
        wait (reported);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
// Clock and reset source for the cache testbench.
// 100 ns clock; reset held high for the first five rising edges.

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #(PERIOD / 10) o_rst = 1'b0;  // released just after the edge like other inputs
    end

endmodule

/* src/cache_ctrl.sv */
// Cache controller: holds one processor request, looks it up in the four
// ways, and runs hit writes, line fills and dirty write-backs.
// Drives both outside ports; the processor sees waitrequest whenever the
// FSM is not idle, the memory side gets level read/write requests.

module cache_ctrl import cache_pkg::*; #(
    parameter  int INDEX_W  = 14,
    localparam int OFF_W    = $clog2(WORDS),
    localparam int LINE_A_W = ADDR_W - OFF_W,
    localparam int TAG_W    = LINE_A_W - INDEX_W
) (
    input  logic                clk,
    input  logic                rst,

    input  cpu_req_t            i_p_req,
    output word_t               o_p_readdata,
    output logic                o_p_readdata_valid,
    output logic                o_p_waitrequest,

    output mem_req_t            o_m_req,
    input  mem_rsp_t            i_m_rsp,

    output logic [INDEX_W-1:0]  o_index,
    output logic [TAG_W-1:0]    o_tag,
    output line_t               o_wdata,
    output logic [3:0]          o_byte_en,
    output logic [WORDS-1:0]    o_word_en,
    output way_mask_t           o_way_write,
    output logic                o_clean_fill,
    input  way_mask_t           i_hit,
    input  way_mask_t           i_valid,
    input  way_mask_t           i_dirty,
    input  line_t               i_lines [WAYS],
    input  logic [LINE_A_W-1:0] i_victim_addr [WAYS],

    output logic                o_touch,
    output logic                o_first_fill,
    output way_idx_t            o_touch_way,
    input  way_idx_t            i_lru_way
);

    localparam int PAD_W = MEM_ADDR_W - LINE_A_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_HIT_WRITE,
        ST_FETCH_REQ,
        ST_FETCH_WAIT,
        ST_FETCH_MERGE,
        ST_WB_SETUP,
        ST_WB
    } state_t;

    state_t                state;
    cpu_req_t              req_q;
    way_idx_t              way_sel;  // way being written or filled
    logic [MEM_ADDR_W-1:0] m_addr;
    line_t                 m_wdata;
    logic                  m_read;
    logic                  m_write;

    logic [OFF_W-1:0]      word_sel;
    logic [LINE_A_W-1:0]   line_addr;
    way_idx_t              hit_way;
    way_idx_t              fill_way;
    logic                  any_hit;
    logic                  fill_cycle;

    assign word_sel   = req_q.addr[OFF_W-1:0];
    assign line_addr  = req_q.addr[ADDR_W-1:OFF_W];
    assign any_hit    = |i_hit;
    assign fill_cycle = (state == ST_FETCH_WAIT);

    // lowest hitting way; lowest invalid way, else the least recent one
    always_comb begin
        hit_way  = '0;
        fill_way = i_lru_way;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (i_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
            if (!i_valid[w]) begin
                fill_way = way_idx_t'(w);
            end
        end
    end

    // idle takes the index straight from the port so RAM data is ready in compare
    assign o_index = (state == ST_IDLE) ? i_p_req.addr[OFF_W +: INDEX_W]
                                        : req_q.addr[OFF_W +: INDEX_W];
    assign o_tag   = req_q.addr[ADDR_W-1 -: TAG_W];

    assign o_wdata      = fill_cycle ? i_m_rsp.readdata : {WORDS{req_q.writedata}};
    assign o_byte_en    = fill_cycle ? 4'hf : req_q.byte_en;
    assign o_word_en    = fill_cycle ? '1 : (WORDS'(1) << word_sel);
    assign o_clean_fill = fill_cycle;

    always_comb begin
        o_way_write = '0;
        if ((fill_cycle && i_m_rsp.readdata_valid) ||
            state == ST_HIT_WRITE || state == ST_FETCH_MERGE) begin
            o_way_write[way_sel] = 1'b1;
        end
    end

    // order update happens once per request, in compare
    assign o_touch      = (state == ST_COMPARE);
    assign o_touch_way  = any_hit ? hit_way : fill_way;
    assign o_first_fill = !any_hit && !i_valid[0];

    assign o_p_waitrequest = (state != ST_IDLE);

    always_comb begin
        o_m_req.addr      = m_addr;
        o_m_req.writedata = m_wdata;
        o_m_req.read      = m_read;
        o_m_req.write     = m_write;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= ST_IDLE;
            o_p_readdata_valid <= 1'b0;
            m_read             <= 1'b0;
            m_write            <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_p_req.read || i_p_req.write) begin
                        state <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (any_hit && req_q.write) begin
                        state <= ST_HIT_WRITE;
                    end else if (any_hit) begin
                        state              <= ST_IDLE;
                        o_p_readdata_valid <= 1'b1;
                    end else if (i_valid[fill_way] && i_dirty[fill_way]) begin
                        state <= ST_WB_SETUP;
                    end else begin
                        state  <= ST_FETCH_REQ;
                        m_read <= 1'b1;
                    end
                end
                ST_HIT_WRITE: state <= ST_IDLE;
                ST_FETCH_REQ: begin
                    if (!i_m_rsp.waitrequest) begin
                        m_read <= 1'b0;
                        state  <= ST_FETCH_WAIT;
                    end
                end
                ST_FETCH_WAIT: begin
                    if (i_m_rsp.readdata_valid) begin
                        if (req_q.write) begin
                            state <= ST_FETCH_MERGE;  // merge the write into the new line
                        end else begin
                            state              <= ST_IDLE;
                            o_p_readdata_valid <= 1'b1;
                        end
                    end
                end
                ST_FETCH_MERGE: state <= ST_IDLE;
                ST_WB_SETUP: begin
                    m_write <= 1'b1;
                    state   <= ST_WB;
                end
                ST_WB: begin
                    if (!i_m_rsp.waitrequest) begin
                        m_write <= 1'b0;
                        m_read  <= 1'b1;  // fetch follows the write-back directly
                        state   <= ST_FETCH_REQ;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request, way choice and memory payload
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: req_q <= i_p_req;
            ST_COMPARE: begin
                way_sel <= any_hit ? hit_way : fill_way;
                m_addr  <= {line_addr, {PAD_W{1'b0}}};
                if (any_hit) begin
                    o_p_readdata <= i_lines[hit_way][word_sel];
                end
            end
            ST_FETCH_WAIT: begin
                if (i_m_rsp.readdata_valid) begin
                    o_p_readdata <= i_m_rsp.readdata[word_sel];
                end
            end
            ST_WB_SETUP: begin
                m_addr  <= {i_victim_addr[way_sel], {PAD_W{1'b0}}};
                m_wdata <= i_lines[way_sel];
            end
            ST_WB: begin
                if (!i_m_rsp.waitrequest) begin
                    m_addr <= {line_addr, {PAD_W{1'b0}}};
                end
            end
            default: ;
        endcase
    end

endmodule

/* src/cache_pkg.sv */
// Shared widths and types for the four-way write-back cache.
// Every RTL module pulls these in with a wildcard import in its header;
// the bench uses the same request and response structs at the DUT ports.

package cache_pkg;

    localparam int ADDR_W     = 25;  // processor word address
    localparam int MEM_ADDR_W = 26;  // line address plus three zero bits
    localparam int WORD_W     = 32;
    localparam int WORDS      = 4;   // words per line
    localparam int WAYS       = 4;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS-1:0] line_t;

    typedef logic [WAYS-1:0] way_mask_t;
    typedef logic [$clog2(WAYS)-1:0] way_idx_t;

    // field 0 is least recent, field WAYS-1 most recent
    typedef way_idx_t [WAYS-1:0] lru_order_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        byte_en;
        word_t             writedata;
        logic              read;   // one-cycle strobe
        logic              write;  // one-cycle strobe
    } cpu_req_t;

    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        line_t                 writedata;
        logic                  read;   // held until waitrequest low
        logic                  write;
    } mem_req_t;

    typedef struct packed {
        line_t readdata;
        logic  readdata_valid;
        logic  waitrequest;
    } mem_rsp_t;

endpackage

/* src/cache_ram.sv */
// Simple dual-port RAM: one write port, one read port, registered read.
// Contents start at zero so tag entries come up invalid.

module cache_ram #(
    parameter int WIDTH   = 8,
    parameter int DEPTH_W = 4
) (
    input  logic               clk,
    input  logic [DEPTH_W-1:0] i_wr_addr,
    input  logic               i_wr_en,
    input  logic [WIDTH-1:0]   i_wr_data,
    input  logic [DEPTH_W-1:0] i_rd_addr,
    output logic [WIDTH-1:0]   o_rd_data
);

    logic [WIDTH-1:0] mem [2**DEPTH_W] = '{default: '0};

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_addr];  // old data on a same-address write
    end

endmodule

/* src/cache_top.sv */
// Top level of the four-way write-back cache. Wires the controller to the
// four ways and the replacement order memory; INDEX_W sets the number of
// sets and is passed down to every block that holds per-set state.

module cache_top import cache_pkg::*; #(
    parameter  int INDEX_W  = 14,
    localparam int OFF_W    = $clog2(WORDS),
    localparam int LINE_A_W = ADDR_W - OFF_W,
    localparam int TAG_W    = LINE_A_W - INDEX_W
) (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t i_p_req,
    output word_t    o_p_readdata,
    output logic     o_p_readdata_valid,
    output logic     o_p_waitrequest,
    output mem_req_t o_m_req,
    input  mem_rsp_t i_m_rsp
);

    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    line_t               wdata;
    logic [3:0]          byte_en;
    logic [WORDS-1:0]    word_en;
    way_mask_t           way_write;
    logic                clean_fill;
    way_mask_t           way_hit;
    way_mask_t           way_valid;
    way_mask_t           way_dirty;
    line_t               way_line [WAYS];
    logic [LINE_A_W-1:0] victim_addr [WAYS];
    logic                touch;
    logic                first_fill;
    way_idx_t            touch_way;
    way_idx_t            lru_way;

    cache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (i_p_req),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_req            (o_m_req),
        .i_m_rsp            (i_m_rsp),
        .o_index            (index),
        .o_tag              (tag),
        .o_wdata            (wdata),
        .o_byte_en          (byte_en),
        .o_word_en          (word_en),
        .o_way_write        (way_write),
        .o_clean_fill       (clean_fill),
        .i_hit              (way_hit),
        .i_valid            (way_valid),
        .i_dirty            (way_dirty),
        .i_lines            (way_line),
        .i_victim_addr      (victim_addr),
        .o_touch            (touch),
        .o_first_fill       (first_fill),
        .o_touch_way        (touch_way),
        .i_lru_way          (lru_way)
    );

    lru_order #(.INDEX_W(INDEX_W)) u_lru (
        .clk          (clk),
        .i_index      (index),
        .i_touch      (touch),
        .i_way        (touch_way),
        .i_first_fill (first_fill),
        .o_lru_way    (lru_way)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_way #(.INDEX_W(INDEX_W)) u_way (
            .clk           (clk),
            .i_index       (index),
            .i_tag         (tag),
            .i_wdata       (wdata),
            .i_byte_en     (byte_en),
            .i_word_en     (word_en),
            .i_write       (way_write[w]),
            .i_clean_fill  (clean_fill),
            .o_line        (way_line[w]),
            .o_victim_addr (victim_addr[w]),
            .o_hit         (way_hit[w]),
            .o_valid       (way_valid[w]),
            .o_dirty       (way_dirty[w])
        );
    end

endmodule

/* src/cache_way.sv */
// One way of the cache: sixteen byte-lane data RAMs plus one RAM holding
// {dirty, valid, tag} per set. All reads lag the index by one cycle.
// The controller drives one shared index and lookup tag to all four ways.

module cache_way import cache_pkg::*; #(
    parameter  int INDEX_W  = 14,
    localparam int OFF_W    = $clog2(WORDS),
    localparam int LINE_A_W = ADDR_W - OFF_W,
    localparam int TAG_W    = LINE_A_W - INDEX_W
) (
    input  logic                clk,
    input  logic [INDEX_W-1:0]  i_index,
    input  logic [TAG_W-1:0]    i_tag,
    input  line_t               i_wdata,
    input  logic [3:0]          i_byte_en,
    input  logic [WORDS-1:0]    i_word_en,
    input  logic                i_write,
    input  logic                i_clean_fill,
    output line_t               o_line,
    output logic [LINE_A_W-1:0] o_victim_addr,
    output logic                o_hit,
    output logic                o_valid,
    output logic                o_dirty
);

    localparam int BYTES = WORD_W / 8;

    logic [TAG_W+1:0] tag_wr;
    logic [TAG_W+1:0] tag_rd;
    logic [TAG_W-1:0] stored_tag;

    for (genvar w = 0; w < WORDS; w++) begin : g_word
        for (genvar b = 0; b < BYTES; b++) begin : g_byte
            cache_ram #(
                .WIDTH   (8),
                .DEPTH_W (INDEX_W)
            ) u_data (
                .clk       (clk),
                .i_wr_addr (i_index),
                .i_wr_en   (i_write && i_word_en[w] && i_byte_en[b]),
                .i_wr_data (i_wdata[w][8*b +: 8]),
                .i_rd_addr (i_index),
                .o_rd_data (o_line[w][8*b +: 8])
            );
        end
    end

    // a fill from memory lands clean; any processor write leaves it dirty
    assign tag_wr = {~i_clean_fill, 1'b1, i_tag};

    cache_ram #(
        .WIDTH   (TAG_W + 2),
        .DEPTH_W (INDEX_W)
    ) u_tag (
        .clk       (clk),
        .i_wr_addr (i_index),
        .i_wr_en   (i_write),
        .i_wr_data (tag_wr),
        .i_rd_addr (i_index),
        .o_rd_data (tag_rd)
    );

    assign o_dirty    = tag_rd[TAG_W+1];
    assign o_valid    = tag_rd[TAG_W];
    assign stored_tag = tag_rd[TAG_W-1:0];

    assign o_hit         = o_valid && (stored_tag == i_tag);
    assign o_victim_addr = {stored_tag, i_index};  // line address for write-back

endmodule

/* src/lru_order.sv */
// Replacement order per set, one byte each: four way numbers from least
// recent (low field) to most recent (high field). A touch writes back the
// order with the given way moved to the top; the read side has the same
// one-cycle latency as the ways, so the touch belongs in the compare cycle.

module lru_order import cache_pkg::*; #(
    parameter int INDEX_W = 14
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_touch,
    input  way_idx_t           i_way,
    input  logic               i_first_fill,
    output way_idx_t           o_lru_way
);

    // way 0 least recent; used on the very first fill of a set
    localparam lru_order_t START_ORDER = {2'd3, 2'd2, 2'd1, 2'd0};

    lru_order_t cur_order;
    lru_order_t base_order;
    lru_order_t next_order;

    // fields above the touched way drop one place, the way goes on top
    function automatic lru_order_t move_to_mru(lru_order_t ord, way_idx_t way);
        lru_order_t res;
        logic       found;
        found = 1'b0;
        for (int i = 0; i < WAYS - 1; i++) begin
            if (ord[i] == way) begin
                found = 1'b1;
            end
            res[i] = found ? ord[i+1] : ord[i];
        end
        res[WAYS-1] = way;
        return res;
    endfunction

    cache_ram #(
        .WIDTH   ($bits(lru_order_t)),
        .DEPTH_W (INDEX_W)
    ) u_order (
        .clk       (clk),
        .i_wr_addr (i_index),
        .i_wr_en   (i_touch),
        .i_wr_data (next_order),
        .i_rd_addr (i_index),
        .o_rd_data (cur_order)
    );

    assign base_order = i_first_fill ? START_ORDER : cur_order;
    assign next_order = move_to_mru(base_order, i_way);
    assign o_lru_way  = cur_order[0];

endmodule
